//--- include/rv32i_macros.svh
// ~~~~~~~~~~~~~~~~~~~~
// Shared constants for the RV32I pipelined core.
// Included by the package, the RTL and the testbench.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

`define XLEN        32
`define NUM_REGS    32
`define RESET_PC    32'h0000_0000
`define NOP_INST    32'h0000_0013     // addi x0, x0, 0

// Opcode map, inst[6:0]
`define OP_R        7'b0110011
`define OP_I_ARITH  7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111

`endif

//--- hdl/rv32i_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Common types of the RV32I core.
// Imported by every RTL module and the testbench.
// ~~~~~~~~~~~~~~~~~~~~
`include "rv32i_macros.svh"

package rv32i_pkg;

  typedef logic [`XLEN-1:0] word_t;     // Data or address word
  typedef logic [4:0]       reg_idx_t;  // Register number

  // ALU operation codes
  typedef enum logic [4:0] {
    ALU_ADD = 5'b00000,
    ALU_AND = 5'b00001,
    ALU_OR  = 5'b00010,
    ALU_XOR = 5'b00011,
    ALU_SLL = 5'b00100,
    ALU_SUB = 5'b10000
  } alu_op_t;

  // Execute operand source
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,   // Value read in decode
    FWD_MEM  = 2'd1,   // ALU result in memory stage
    FWD_WB   = 2'd2    // Writeback value
  } fwd_sel_t;

  // Branch funct3 encodings
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_t;

endpackage

//--- hdl/rv32i_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Instruction decoder of the RV32I core.
// Purely combinational, sits on the decode-stage instruction and
// returns control bits, ALU operation and sign-extended immediate.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module rv32i_decoder (
  input  rv32i_pkg::word_t   inst,
  output logic               regwrite,
  output logic               alusrc,
  output logic               memtoreg,
  output logic               memwrite,
  output logic               branch,
  output logic               jal,
  output logic               auipc,
  output logic               lui,
  output rv32i_pkg::alu_op_t alu_op,
  output rv32i_pkg::word_t   imm
);
  import rv32i_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;  // Selects sub over add

  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7_b5 = inst[30];

  always_comb
  begin
    {regwrite, alusrc, memtoreg, memwrite, branch, jal, auipc, lui} = 8'b0;
    alu_op = ALU_ADD;
    imm    = '0;
    case (opcode)
      `OP_R:
      begin
        regwrite = 1'b1;
        case ({funct7_b5, funct3})
          4'b1_000: alu_op = ALU_SUB;
          4'b0_111: alu_op = ALU_AND;
          4'b0_110: alu_op = ALU_OR;
          4'b0_100: alu_op = ALU_XOR;
          4'b0_001: alu_op = ALU_SLL;
          default:  alu_op = ALU_ADD;
        endcase
      end
      `OP_I_ARITH:
      begin
        {regwrite, alusrc} = 2'b11;
        imm = {{20{inst[31]}}, inst[31:20]};
        case (funct3)
          3'b111:  alu_op = ALU_AND;
          3'b110:  alu_op = ALU_OR;
          3'b100:  alu_op = ALU_XOR;
          3'b001:  alu_op = ALU_SLL;   // shamt sits in imm[4:0]
          default: alu_op = ALU_ADD;
        endcase
      end
      `OP_LOAD:
      begin
        {regwrite, alusrc, memtoreg} = 3'b111;
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      `OP_STORE:
      begin
        {alusrc, memwrite} = 2'b11;
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      `OP_BRANCH:
      begin
        branch = 1'b1;
        alu_op = ALU_SUB;   // Flags come from rs1 - rs2
        imm    = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      `OP_JAL:
      begin
        {regwrite, jal} = 2'b11;
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      `OP_LUI:
      begin
        {regwrite, alusrc, lui} = 3'b111;
        imm = {inst[31:12], 12'b0};
      end
      `OP_AUIPC:
      begin
        {regwrite, alusrc, auipc} = 3'b111;
        imm = {inst[31:12], 12'b0};
      end
      default: ;  // Unknown opcode acts as a bubble
    endcase
  end

endmodule

//--- hdl/rv32i_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~
// Integer register file, two reads and one write.
// Read in decode, written from writeback with write-through.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module rv32i_regfile (
  input  logic                clk,
  input  logic                reset,
  input  logic                we,
  input  rv32i_pkg::reg_idx_t rs1,
  input  rv32i_pkg::reg_idx_t rs2,
  input  rv32i_pkg::reg_idx_t rd,
  input  rv32i_pkg::word_t    rd_data,
  output rv32i_pkg::word_t    rs1_data,
  output rv32i_pkg::word_t    rs2_data
);
  import rv32i_pkg::*;

  word_t regs [`NUM_REGS];
  logic  wr_en;   // x0 stays untouched

  assign wr_en = we && (rd != '0);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
      regs[rd] <= rd_data;
  end

  // Same-cycle bypass of the writeback value
  assign rs1_data = (wr_en && (rd == rs1)) ? rd_data : regs[rs1];
  assign rs2_data = (wr_en && (rd == rs2)) ? rd_data : regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    ((rs1 == '0) -> (rs1_data == '0)) && ((rs2 == '0) -> (rs2_data == '0)));

endmodule

//--- hdl/rv32i_alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// Execute-stage ALU with N, Z, C, V flags.
// Flags follow the shared adder, so branches use ALU_SUB.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_alu (
  input  rv32i_pkg::word_t   a,
  input  rv32i_pkg::word_t   b,
  input  rv32i_pkg::alu_op_t op,
  output rv32i_pkg::word_t   result,
  output logic               n,
  output logic               z,
  output logic               c,
  output logic               v
);
  import rv32i_pkg::*;

  localparam int W = $bits(word_t);

  logic       sub;
  word_t      b_eff;
  logic [W:0] sum;   // Extra bit holds carry-out

  assign sub   = (op == ALU_SUB);
  assign b_eff = sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{W{1'b0}}, sub};

  always_comb
  begin
    case (op)
      ALU_ADD, ALU_SUB: result = sum[W-1:0];
      ALU_AND:          result = a & b;
      ALU_OR:           result = a | b;
      ALU_XOR:          result = a ^ b;
      ALU_SLL:          result = a << b[4:0];
      default:          result = '0;
    endcase
  end

  assign n = sum[W-1];
  assign z = (sum[W-1:0] == '0);
  assign c = sum[W];   // On subtract, set means no borrow
  assign v = (a[W-1] == b_eff[W-1]) && (sum[W-1] != a[W-1]);

endmodule

//--- hdl/rv32i_hazard_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Pipeline hazard logic.
// Flags a load-use stall and picks the forwarding source
// for both execute operands, the second one also feeds store data.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_hazard_unit (
  input  rv32i_pkg::reg_idx_t rs1_id,
  input  rv32i_pkg::reg_idx_t rs2_id,
  input  rv32i_pkg::reg_idx_t rs1_ex,
  input  rv32i_pkg::reg_idx_t rs2_ex,
  input  rv32i_pkg::reg_idx_t rd_ex,
  input  rv32i_pkg::reg_idx_t rd_mem,
  input  rv32i_pkg::reg_idx_t rd_wb,
  input  logic                memtoreg_ex,
  input  logic                regwrite_mem,
  input  logic                memtoreg_mem,
  input  logic                regwrite_wb,
  output logic                stall,
  output rv32i_pkg::fwd_sel_t fwd_a,
  output rv32i_pkg::fwd_sel_t fwd_b
);
  import rv32i_pkg::*;

  // Newest producer wins, a load in memory stage has no data yet
  function automatic fwd_sel_t pick_source(input reg_idx_t rs);
    fwd_sel_t sel;
    if (regwrite_mem && !memtoreg_mem && (rd_mem != '0) && (rd_mem == rs))
      sel = FWD_MEM;
    else if (regwrite_wb && (rd_wb != '0) && (rd_wb == rs))
      sel = FWD_WB;
    else
      sel = FWD_NONE;
    return sel;
  endfunction

  assign fwd_a = pick_source(rs1_ex);
  assign fwd_b = pick_source(rs2_ex);

  // Load in execute feeding the instruction in decode
  assign stall = memtoreg_ex && (rd_ex != '0) &&
                 ((rd_ex == rs1_id) || (rd_ex == rs2_id));

endmodule

//--- hdl/rv32i_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Five-stage pipelined RV32I core, top level.
// Fetch, decode, execute, memory and writeback with forwarding,
// load-use interlock and execute-stage branch resolution.
// Instruction and data memories sit outside and answer in-cycle.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module rv32i_core (
  input  logic             clk,
  input  logic             reset,
  output rv32i_pkg::word_t pc,
  input  rv32i_pkg::word_t inst,
  output logic             mem_write,
  output rv32i_pkg::word_t mem_addr,
  output rv32i_pkg::word_t mem_wdata,
  input  rv32i_pkg::word_t mem_rdata
);
  import rv32i_pkg::*;

  // Fetch/decode
  word_t    inst_id, pc_id;
  reg_idx_t rs1_id, rs2_id, rd_id;
  logic     regwrite_id, alusrc_id, memtoreg_id, memwrite_id;
  logic     branch_id, jal_id, auipc_id, lui_id;
  alu_op_t  alu_op_id;
  word_t    imm_id, rs1_data_id, rs2_data_id;

  // Decode/execute
  logic         regwrite_ex, alusrc_ex, memtoreg_ex, memwrite_ex;
  logic         branch_ex, jal_ex, auipc_ex, lui_ex;
  alu_op_t      alu_op_ex;
  branch_cond_t br_cond_ex;
  word_t        rs1_val_ex, rs2_val_ex, imm_ex, pc_ex;
  reg_idx_t     rs1_ex, rs2_ex, rd_ex;

  // Execute datapath
  fwd_sel_t fwd_a, fwd_b;
  word_t    rs1_fwd, rs2_fwd, alu_a, alu_b, alu_ex, target_ex;
  logic     flag_n, flag_z, flag_c, flag_v;
  logic     cond_met, br_taken, redirect, stall;

  // Execute/memory and memory/writeback
  logic     regwrite_mem, memtoreg_mem, memwrite_mem, jal_mem;
  word_t    alu_mem, wdata_mem, pc_mem;
  reg_idx_t rd_mem;
  logic     regwrite_wb, memtoreg_wb, jal_wb;
  word_t    alu_wb, rdata_wb, pc_wb, wb_data;
  reg_idx_t rd_wb;

  // Fetch
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= `RESET_PC;
    else if (redirect)
      pc <= target_ex;
    else if (!stall)
      pc <= pc + word_t'(4);
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      inst_id <= `NOP_INST;
    else if (redirect)
      inst_id <= `NOP_INST;   // Squash the fetched instruction
    else if (!stall)
      inst_id <= inst;
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
      pc_id <= pc;
  end

  // Decode
  assign rs1_id = inst_id[19:15];
  assign rs2_id = inst_id[24:20];
  assign rd_id  = inst_id[11:7];

  rv32i_decoder u_decoder (
    .inst     (inst_id),
    .regwrite (regwrite_id),
    .alusrc   (alusrc_id),
    .memtoreg (memtoreg_id),
    .memwrite (memwrite_id),
    .branch   (branch_id),
    .jal      (jal_id),
    .auipc    (auipc_id),
    .lui      (lui_id),
    .alu_op   (alu_op_id),
    .imm      (imm_id)
  );

  rv32i_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .we       (regwrite_wb),
    .rs1      (rs1_id),
    .rs2      (rs2_id),
    .rd       (rd_wb),
    .rd_data  (wb_data),
    .rs1_data (rs1_data_id),
    .rs2_data (rs2_data_id)
  );

  rv32i_hazard_unit u_hazard (
    .rs1_id       (rs1_id),
    .rs2_id       (rs2_id),
    .rs1_ex       (rs1_ex),
    .rs2_ex       (rs2_ex),
    .rd_ex        (rd_ex),
    .rd_mem       (rd_mem),
    .rd_wb        (rd_wb),
    .memtoreg_ex  (memtoreg_ex),
    .regwrite_mem (regwrite_mem),
    .memtoreg_mem (memtoreg_mem),
    .regwrite_wb  (regwrite_wb),
    .stall        (stall),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  // Bubble on load-use or on a redirect from execute
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      {regwrite_ex, alusrc_ex, memtoreg_ex, memwrite_ex} <= 4'b0;
      {branch_ex, jal_ex, auipc_ex, lui_ex} <= 4'b0;
      alu_op_ex  <= ALU_ADD;
      br_cond_ex <= BR_EQ;
    end
    else if (stall || redirect)
    begin
      {regwrite_ex, alusrc_ex, memtoreg_ex, memwrite_ex} <= 4'b0;
      {branch_ex, jal_ex, auipc_ex, lui_ex} <= 4'b0;
      alu_op_ex  <= ALU_ADD;
      br_cond_ex <= BR_EQ;
    end
    else
    begin
      {regwrite_ex, alusrc_ex, memtoreg_ex, memwrite_ex} <=
        {regwrite_id, alusrc_id, memtoreg_id, memwrite_id};
      {branch_ex, jal_ex, auipc_ex, lui_ex} <= {branch_id, jal_id, auipc_id, lui_id};
      alu_op_ex  <= alu_op_id;
      br_cond_ex <= branch_cond_t'(inst_id[14:12]);
    end
  end

  always_ff @(posedge clk)
  begin
    rs1_val_ex <= rs1_data_id;
    rs2_val_ex <= rs2_data_id;
    imm_ex     <= imm_id;
    pc_ex      <= pc_id;
    rs1_ex     <= rs1_id;
    rs2_ex     <= rs2_id;
    rd_ex      <= rd_id;
  end

  // Execute
  always_comb
  begin
    case (fwd_a)
      FWD_MEM: rs1_fwd = alu_mem;
      FWD_WB:  rs1_fwd = wb_data;
      default: rs1_fwd = rs1_val_ex;
    endcase
    case (fwd_b)
      FWD_MEM: rs2_fwd = alu_mem;
      FWD_WB:  rs2_fwd = wb_data;
      default: rs2_fwd = rs2_val_ex;
    endcase
  end

  assign alu_a = auipc_ex ? pc_ex : (lui_ex ? '0 : rs1_fwd);
  assign alu_b = alusrc_ex ? imm_ex : rs2_fwd;

  rv32i_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op_ex),
    .result (alu_ex),
    .n      (flag_n),
    .z      (flag_z),
    .c      (flag_c),
    .v      (flag_v)
  );

  always_comb
  begin
    case (br_cond_ex)
      BR_EQ:   cond_met = flag_z;
      BR_NE:   cond_met = !flag_z;
      BR_LT:   cond_met = (flag_n != flag_v);
      BR_GE:   cond_met = (flag_n == flag_v);
      BR_LTU:  cond_met = !flag_c;
      BR_GEU:  cond_met = flag_c;
      default: cond_met = 1'b0;
    endcase
  end

  assign br_taken  = branch_ex && cond_met;
  assign redirect  = br_taken || jal_ex;
  assign target_ex = pc_ex + imm_ex;   // B or J immediate, picked in decode

  // Memory
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      {regwrite_mem, memtoreg_mem, memwrite_mem, jal_mem} <= 4'b0;
    else
      {regwrite_mem, memtoreg_mem, memwrite_mem, jal_mem} <=
        {regwrite_ex, memtoreg_ex, memwrite_ex, jal_ex};
  end

  always_ff @(posedge clk)
  begin
    alu_mem   <= alu_ex;
    wdata_mem <= rs2_fwd;   // Store data after forwarding
    rd_mem    <= rd_ex;
    pc_mem    <= pc_ex;
  end

  assign mem_write = memwrite_mem;
  assign mem_addr  = alu_mem;
  assign mem_wdata = wdata_mem;

  // Writeback
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      {regwrite_wb, memtoreg_wb, jal_wb} <= 3'b0;
    else
      {regwrite_wb, memtoreg_wb, jal_wb} <= {regwrite_mem, memtoreg_mem, jal_mem};
  end

  always_ff @(posedge clk)
  begin
    alu_wb   <= alu_mem;
    rdata_wb <= mem_rdata;
    rd_wb    <= rd_mem;
    pc_wb    <= pc_mem;
  end

  assign wb_data = jal_wb ? (pc_wb + word_t'(4)) : (memtoreg_wb ? rdata_wb : alu_wb);

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

  a_store_aligned: assert property (@(posedge clk) disable iff (reset)
    mem_write |-> (mem_addr[1:0] == 2'b00));

endmodule

//--- include/rv32i_test_program.svh
// ~~~~~~~~~~~~~~~~~~~~
// Test program and expected store stream for the core testbench.
// Included inside the testbench module. build_program fills imem
// and queues each expected store next to the instruction making it.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef RV32I_TEST_PROGRAM_SVH
`define RV32I_TEST_PROGRAM_SVH

localparam word_t STORE_BASE = 32'h0000_0100;   // Held in x10
localparam word_t DONE_ADDR  = 32'h0000_03FC;
localparam word_t SHADOW     = 32'h0000_2023;   // sw x0, 0(x0), must never execute

int prog_len;
int store_off;

function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] f3,
                                 input reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, `OP_R};
endfunction

function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                 input logic [2:0] f3, input reg_idx_t rd,
                                 input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                 input reg_idx_t rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
endfunction

function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
endfunction

function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                 input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic word_t next_pc();
  return word_t'(prog_len) << 2;
endfunction

task automatic put_inst(input word_t w);
  imem[prog_len] = w;
  prog_len++;
endtask

// sw rs2, store_off(x10) plus its expected entry
task automatic store_and_expect(input string name, input reg_idx_t rs2, input word_t data);
  put_inst(s_type(12'(store_off), rs2, 5'd10));
  exp_name.push_back(name);
  exp_addr.push_back(STORE_BASE + word_t'(store_off));
  exp_data.push_back(data);
  store_off += 4;
endtask

// Taken skips two shadow stores, not taken falls into its marker
task automatic branch_case(input string name, input branch_cond_t cond,
                           input reg_idx_t rs1, input reg_idx_t rs2, input logic taken);
  if (taken)
  begin
    put_inst(b_type(13'd12, rs2, rs1, cond));
    put_inst(SHADOW);
    put_inst(SHADOW);
    store_and_expect(name, 5'd20, 32'h0000_007A);
  end
  else
  begin
    put_inst(b_type(13'd8, rs2, rs1, cond));
    store_and_expect(name, 5'd21, 32'h0000_004E);
  end
endtask

task automatic build_program();
  word_t link;
  word_t auipc_pc;
  prog_len  = 0;
  store_off = 0;
  for (int i = 0; i < IMEM_WORDS; i++)
    imem[i] = `NOP_INST;

  put_inst(i_type(12'h100, 5'd0, 3'b000, 5'd10, `OP_I_ARITH));   // x10 = store base
  put_inst(i_type(12'd100, 5'd0, 3'b000, 5'd1, `OP_I_ARITH));    // x1 = 100
  put_inst(i_type(12'hFF9, 5'd0, 3'b000, 5'd2, `OP_I_ARITH));    // x2 = -7
  put_inst(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));             // x2 from MEM, x1 from WB
  store_and_expect("add", 5'd3, 32'h0000_005D);
  put_inst(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
  store_and_expect("sub", 5'd4, 32'h0000_006B);
  put_inst(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
  put_inst(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
  put_inst(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
  store_and_expect("and", 5'd5, 32'h0000_0060);
  store_and_expect("or", 5'd6, 32'hFFFF_FFFD);
  store_and_expect("xor", 5'd7, 32'hFFFF_FF9D);
  put_inst(i_type(12'd3, 5'd0, 3'b000, 5'd8, `OP_I_ARITH));
  put_inst(r_type(7'h00, 5'd8, 5'd1, 3'b001, 5'd9));
  store_and_expect("sll", 5'd9, 32'h0000_0320);
  put_inst(i_type(12'h0F0, 5'd2, 3'b111, 5'd11, `OP_I_ARITH));
  put_inst(i_type(12'hF00, 5'd1, 3'b110, 5'd12, `OP_I_ARITH));
  put_inst(i_type(12'h7FF, 5'd1, 3'b100, 5'd13, `OP_I_ARITH));
  put_inst(i_type(12'h004, 5'd1, 3'b001, 5'd14, `OP_I_ARITH));
  store_and_expect("andi", 5'd11, 32'h0000_00F0);
  store_and_expect("ori", 5'd12, 32'hFFFF_FF64);
  store_and_expect("xori", 5'd13, 32'h0000_079B);
  store_and_expect("slli", 5'd14, 32'h0000_0640);

  put_inst(i_type(12'd0, 5'd10, 3'b010, 5'd15, `OP_LOAD));      // Reads the add result
  put_inst(i_type(12'd1, 5'd15, 3'b000, 5'd16, `OP_I_ARITH));   // Load-use stall
  store_and_expect("lw then addi", 5'd16, 32'h0000_005E);
  put_inst(i_type(12'd4, 5'd10, 3'b010, 5'd17, `OP_LOAD));
  store_and_expect("lw then sw", 5'd17, 32'h0000_006B);          // Stall, then WB store data

  put_inst(u_type(20'h80000, 5'd18, `OP_LUI));                   // x18 = 0x80000000
  put_inst(u_type(20'h80000, 5'd19, `OP_LUI));
  put_inst(i_type(12'hFFF, 5'd19, 3'b000, 5'd19, `OP_I_ARITH));  // x19 = 0x7FFFFFFF
  put_inst(i_type(12'h07A, 5'd0, 3'b000, 5'd20, `OP_I_ARITH));   // Taken marker
  put_inst(i_type(12'h04E, 5'd0, 3'b000, 5'd21, `OP_I_ARITH));   // Not-taken marker
  branch_case("beq taken", BR_EQ, 5'd1, 5'd1, 1'b1);
  branch_case("beq not taken", BR_EQ, 5'd1, 5'd2, 1'b0);
  branch_case("bne taken", BR_NE, 5'd1, 5'd2, 1'b1);
  branch_case("bne not taken", BR_NE, 5'd1, 5'd1, 1'b0);
  branch_case("blt taken", BR_LT, 5'd18, 5'd19, 1'b1);
  branch_case("blt not taken", BR_LT, 5'd19, 5'd18, 1'b0);
  branch_case("bge taken", BR_GE, 5'd1, 5'd2, 1'b1);
  branch_case("bge not taken", BR_GE, 5'd2, 5'd1, 1'b0);
  branch_case("bltu taken", BR_LTU, 5'd1, 5'd2, 1'b1);
  branch_case("bltu not taken", BR_LTU, 5'd2, 5'd1, 1'b0);
  branch_case("bgeu taken", BR_GEU, 5'd18, 5'd19, 1'b1);
  branch_case("bgeu not taken", BR_GEU, 5'd19, 5'd18, 1'b0);

  link = next_pc() + 32'd4;
  put_inst(j_type(21'd12, 5'd23));
  put_inst(SHADOW);
  put_inst(SHADOW);
  store_and_expect("jal link", 5'd23, link);

  put_inst(u_type(20'hABCDE, 5'd24, `OP_LUI));
  store_and_expect("lui", 5'd24, 32'hABCD_E000);
  auipc_pc = next_pc();
  put_inst(u_type(20'h12345, 5'd25, `OP_AUIPC));
  store_and_expect("auipc", 5'd25, 32'h1234_5000 + auipc_pc);

  put_inst(i_type(12'h5A5, 5'd0, 3'b000, 5'd26, `OP_I_ARITH));
  put_inst(s_type(12'(DONE_ADDR - STORE_BASE), 5'd26, 5'd10));
  exp_name.push_back("done");
  exp_addr.push_back(DONE_ADDR);
  exp_data.push_back(32'h0000_05A5);
  put_inst(j_type(21'd0, 5'd0));   // Spin in place
endtask

`endif

//--- tests/tb_rv32i_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the pipelined RV32I core.
// Models both memories, runs the test program and checks every
// store against the expected stream, in order.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module tb_rv32i_core;
  import rv32i_pkg::*;

  localparam int IMEM_WORDS     = 256;
  localparam int DMEM_WORDS     = 256;
  localparam int TIMEOUT_CYCLES = 2000;

  logic  clk;
  logic  reset;
  word_t pc, inst, mem_addr, mem_wdata, mem_rdata;
  logic  mem_write;

  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  string exp_name [$];
  word_t exp_addr [$];
  word_t exp_data [$];

  int   store_idx    = 0;
  int   checks       = 0;
  int   value_errors = 0;
  int   other_errors = 0;
  logic done_seen    = 1'b0;

  `include "rv32i_test_program.svh"

  rv32i_core dut0 (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Both memories answer in the same cycle
  assign inst      = imem[pc[9:2]];
  assign mem_rdata = dmem[mem_addr[9:2]];

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i] <= ~word_t'(i * 4);   // Address-dependent fill
    end
    else if (mem_write)
      dmem[mem_addr[9:2]] <= mem_wdata;
  end

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual)
    begin
      value_errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (expected !== actual)
    begin
      value_errors++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Sampled mid-cycle, a store holds mem_write for one full cycle
  task automatic watch_store();
    if (mem_write)
    begin
      if (store_idx < exp_name.size())
      begin
        check_word({exp_name[store_idx], " addr"}, exp_addr[store_idx], mem_addr);
        check_word({exp_name[store_idx], " data"}, exp_data[store_idx], mem_wdata);
      end
      else
      begin
        other_errors++;
        $display("Unexpected store of %h to address %h after the last expected store",
                 mem_wdata, mem_addr);
      end
      if (mem_addr == DONE_ADDR)
        done_seen = 1'b1;
      store_idx++;
    end
  endtask

  initial
  begin
    int cycles;
    reset = 1'b1;
    build_program();

    repeat (16)
    begin
      @(negedge clk);
      check_bit("mem_write in reset", 1'b0, mem_write);
    end
    reset = 1'b0;
    check_word("first pc", `RESET_PC, pc);

    cycles = 0;
    while (!done_seen && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      cycles++;
      watch_store();
    end
    if (!done_seen)
    begin
      other_errors++;
      $display("Timeout: no store to the done address within %0d cycles", TIMEOUT_CYCLES);
    end

    repeat (8)   // Spin loop must stay silent
    begin
      @(negedge clk);
      watch_store();
    end
    if (store_idx != exp_name.size())
    begin
      other_errors++;
      $display("Saw %0d stores but the program expects %0d", store_idx, exp_name.size());
    end

    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hdl/rv32i_pkg.sv
hdl/rv32i_decoder.sv
hdl/rv32i_regfile.sv
hdl/rv32i_alu.sv
hdl/rv32i_hazard_unit.sv
hdl/rv32i_core.sv
tests/tb_rv32i_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_rv32i_core -o sim_rv32i
./obj_dir/sim_rv32i | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
